/* common/stbuf_pkg.sv */
// shared sizes, enums and structs for the store buffer; imported by every store buffer module
`default_nettype none

package stbuf_pkg;

   // ------------------------------------------------------------
   // sizes
   // ------------------------------------------------------------
   localparam int ADDR_WIDTH   = 16;   // store address
   localparam int DATA_WIDTH   = 32;   // one data word
   localparam int BYTE_WIDTH   = 4;    // bytes per word
   localparam int OFFSET_WIDTH = 2;    // byte offset inside a word

   localparam int DEPTH        = 4;    // queue entries
   localparam int PTR_WIDTH    = 2;    // queue pointer, wraps at DEPTH

   // ------------------------------------------------------------
   // enums
   // ------------------------------------------------------------
   // access size of a committed store
   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   // drain stage, idle or holding a memory write
   typedef enum logic {
      DRAIN_IDLE = 1'b0,
      DRAIN_BUSY = 1'b1
   } drain_state_e;

   // ------------------------------------------------------------
   // structs
   // ------------------------------------------------------------
   // store as it arrives from commit, value in the low lanes
   typedef struct packed {
      logic [ADDR_WIDTH-1:0] addr;
      access_size_e          size;
      logic [DATA_WIDTH-1:0] data;
   } store_req_t;

   // packed store, also the memory write request
   typedef struct packed {
      logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] word_addr;
      logic [BYTE_WIDTH-1:0]              byteen;
      logic [DATA_WIDTH-1:0]              data;     // lane aligned
   } stbuf_entry_t;

   // merged load forwarding result
   typedef struct packed {
      logic [BYTE_WIDTH-1:0] byteen;
      logic [DATA_WIDTH-1:0] data;
   } fwd_result_t;

endpackage

`default_nettype wire

/* stbuf/store_packer.sv */
// packing stage, turns a committed store into a byte-enabled entry held in one register stage
`timescale 1ns/10ps
`default_nettype none

module store_packer
   import stbuf_pkg::*;
(
   input  logic         clk,
   input  logic         reset,

   // committed store in
   input  logic         store_valid,
   input  store_req_t   store,
   output logic         store_ready,

   // packed entry to the queue
   output logic         pack_valid,
   output stbuf_entry_t pack_entry,
   input  logic         pack_ready
);

   logic [BYTE_WIDTH-1:0]   size_byteen;     // enables before the offset shift
   logic [OFFSET_WIDTH-1:0] offset;
   stbuf_entry_t            packed_entry;
   logic                    load;

   // ------------------------------------------------------------
   // size and offset decode
   // ------------------------------------------------------------
   assign offset = store.addr[OFFSET_WIDTH-1:0];

   always_comb begin
      case (store.size)
         SIZE_BYTE: size_byteen = 4'b0001;
         SIZE_HALF: size_byteen = 4'b0011;
         SIZE_WORD: size_byteen = 4'b1111;
         default:   size_byteen = 4'b0000;   // unused encoding writes nothing
      endcase
   end

   always_comb begin
      packed_entry.word_addr = store.addr[ADDR_WIDTH-1:OFFSET_WIDTH];
      packed_entry.byteen    = size_byteen << offset;
      packed_entry.data      = store.data << {offset, 3'b000};   // 8 bits per lane
   end

   // ------------------------------------------------------------
   // one-entry pipeline register
   // ------------------------------------------------------------
   // free slot, or the current entry leaves this cycle
   assign store_ready = ~pack_valid | pack_ready;
   assign load        = store_valid & store_ready;

   always_ff @(posedge clk) begin
      if (reset) begin
         pack_valid        <= 1'b0;
         pack_entry.byteen <= '0;
      end else if (load) begin
         pack_valid <= 1'b1;
         pack_entry <= packed_entry;
      end else if (pack_ready) begin
         pack_valid <= 1'b0;   // moved into the queue
      end
   end

endmodule

`default_nettype wire

/* stbuf/stbuf_queue.sv */
// circular store queue between packer and drain, exposes all entries for load forwarding
`timescale 1ns/10ps
`default_nettype none

module stbuf_queue
   import stbuf_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,

   // push side from the packer
   input  logic                     pack_valid,
   input  stbuf_entry_t             pack_entry,
   output logic                     pack_ready,

   // oldest entry to the drain stage
   output logic                     head_valid,
   output stbuf_entry_t             head_entry,
   input  logic                     pop,

   // full view for forwarding
   output stbuf_entry_t [DEPTH-1:0] entries,
   output logic [DEPTH-1:0]         entry_valid,
   output logic [PTR_WIDTH-1:0]     wr_ptr,

   output logic                     empty,
   output logic                     full
);

   logic [PTR_WIDTH-1:0] rd_ptr;
   logic [PTR_WIDTH:0]   num_valid;   // 0 .. DEPTH
   logic                 push;
   logic                 do_pop;

   // ------------------------------------------------------------
   // occupancy
   // ------------------------------------------------------------
   always_comb begin
      num_valid = '0;
      for (int i = 0; i < DEPTH; i++) begin
         num_valid = num_valid + {{PTR_WIDTH{1'b0}}, entry_valid[i]};
      end
   end

   assign empty = (num_valid == '0);
   assign full  = (num_valid == (PTR_WIDTH+1)'(DEPTH));

   assign pack_ready = ~full;
   assign push       = pack_valid & pack_ready;
   assign do_pop     = pop & head_valid;

   // head is always at the read pointer
   assign head_valid = entry_valid[rd_ptr];
   assign head_entry = entries[rd_ptr];

   // ------------------------------------------------------------
   // pointers and valid bits
   // ------------------------------------------------------------
   // push and pop never hit the same slot, full blocks push and empty blocks pop
   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr      <= '0;
         rd_ptr      <= '0;
         entry_valid <= '0;
      end else begin
         if (push) begin
            entry_valid[wr_ptr] <= 1'b1;
            wr_ptr              <= wr_ptr + PTR_WIDTH'(1);
         end
         if (do_pop) begin
            entry_valid[rd_ptr] <= 1'b0;
            rd_ptr              <= rd_ptr + PTR_WIDTH'(1);
         end
      end
   end

   // ------------------------------------------------------------
   // entry storage
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (push) begin
         entries[wr_ptr] <= pack_entry;
      end
   end

endmodule

`default_nettype wire

/* stbuf/stbuf_forward.sv */
// load forwarding search over all pending stores, youngest match wins per byte, result registered
`timescale 1ns/10ps
`default_nettype none

module stbuf_forward
   import stbuf_pkg::*;
(
   input  logic                     clk,
   input  logic                     reset,

   // load lookup
   input  logic                     ld_valid,
   input  logic [ADDR_WIDTH-1:0]    ld_addr,

   // queue contents
   input  stbuf_entry_t [DEPTH-1:0] entries,
   input  logic [DEPTH-1:0]         entry_valid,
   input  logic [PTR_WIDTH-1:0]     wr_ptr,

   // oldest candidate, the request in the drain stage
   input  logic                     drain_valid,
   input  stbuf_entry_t             drain_entry,

   // youngest candidate, the store in the packer
   input  logic                     pack_valid,
   input  stbuf_entry_t             pack_entry,

   output logic                     fwd_valid,
   output fwd_result_t              fwd
);

   logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] ld_word;
   fwd_result_t                        merged;

   assign ld_word = ld_addr[ADDR_WIDTH-1:OFFSET_WIDTH];

   // overlay one candidate on the running result
   function automatic fwd_result_t merge_one(
      input fwd_result_t                        acc,
      input logic                               vld,
      input stbuf_entry_t                       cand,
      input logic [ADDR_WIDTH-OFFSET_WIDTH-1:0] word
   );
      fwd_result_t res;
      logic        hit;
      res = acc;
      hit = vld & (cand.word_addr == word);
      for (int b = 0; b < BYTE_WIDTH; b++) begin
         if (hit & cand.byteen[b]) begin
            res.byteen[b]       = 1'b1;
            res.data[8*b +: 8]  = cand.data[8*b +: 8];
         end
      end
      return res;
   endfunction

   // ------------------------------------------------------------
   // oldest to youngest search
   // ------------------------------------------------------------
   always_comb begin : search
      logic [PTR_WIDTH-1:0] idx;
      merged = '0;
      merged = merge_one(merged, drain_valid, drain_entry, ld_word);

      // starting at wr_ptr walks the ring oldest first, empty slots drop out
      for (int i = 0; i < DEPTH; i++) begin
         idx    = wr_ptr + PTR_WIDTH'(i);
         merged = merge_one(merged, entry_valid[idx], entries[idx], ld_word);
      end

      merged = merge_one(merged, pack_valid, pack_entry, ld_word);   // just in time
   end

   // ------------------------------------------------------------
   // result register
   // ------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         fwd_valid  <= 1'b0;
         fwd.byteen <= '0;
      end else begin
         fwd_valid <= ld_valid;
         if (ld_valid) begin
            fwd <= merged;
         end
      end
   end

endmodule

`default_nettype wire

/* stbuf/stbuf_drain.sv */
// drain stage, takes the oldest queue entry and holds it as a memory write until accepted
`timescale 1ns/10ps
`default_nettype none

module stbuf_drain
   import stbuf_pkg::*;
(
   input  logic         clk,
   input  logic         reset,

   // oldest entry from the queue
   input  logic         head_valid,
   input  stbuf_entry_t head_entry,
   output logic         pop,

   // data memory write port
   output logic         mem_valid,
   output stbuf_entry_t mem_req,
   input  logic         mem_ready
);

   drain_state_e state;
   drain_state_e state_next;
   logic         accept;

   assign mem_valid = (state == DRAIN_BUSY);
   assign accept    = mem_valid & mem_ready;

   // refill at the accepting edge, no bubble between writes
   assign pop = head_valid & ((state == DRAIN_IDLE) | accept);

   always_comb begin
      state_next = state;
      if (pop) begin
         state_next = DRAIN_BUSY;
      end else if (accept) begin
         state_next = DRAIN_IDLE;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state          <= DRAIN_IDLE;
         mem_req.byteen <= '0;
      end else begin
         state <= state_next;
         if (pop) begin
            mem_req <= head_entry;   // held steady while memory stalls
         end
      end
   end

endmodule

`default_nettype wire

/* src/lsu_stbuf.sv */
// store buffer top, packer into queue into drain, with forwarding search across all three
`timescale 1ns/10ps
`default_nettype none

module lsu_stbuf
   import stbuf_pkg::*;
(
   input  logic                  clk,
   input  logic                  reset,

   // committed stores
   input  logic                  store_valid,
   input  store_req_t            store,
   output logic                  store_ready,

   // data memory writes
   output logic                  mem_valid,
   output stbuf_entry_t          mem_req,
   input  logic                  mem_ready,

   // load lookup
   input  logic                  ld_valid,
   input  logic [ADDR_WIDTH-1:0] ld_addr,
   output logic                  fwd_valid,
   output fwd_result_t           fwd,

   output logic                  empty,
   output logic                  full
);

   // ------------------------------------------------------------
   // internal links
   // ------------------------------------------------------------
   logic                     pack_valid;
   stbuf_entry_t             pack_entry;
   logic                     pack_ready;

   logic                     head_valid;
   stbuf_entry_t             head_entry;
   logic                     pop;

   stbuf_entry_t [DEPTH-1:0] entries;
   logic [DEPTH-1:0]         entry_valid;
   logic [PTR_WIDTH-1:0]     wr_ptr;

   // ------------------------------------------------------------
   // blocks
   // ------------------------------------------------------------
   store_packer packer_i (
      .clk         (clk),
      .reset       (reset),
      .store_valid (store_valid),
      .store       (store),
      .store_ready (store_ready),
      .pack_valid  (pack_valid),
      .pack_entry  (pack_entry),
      .pack_ready  (pack_ready)
   );

   stbuf_queue queue_i (
      .clk         (clk),
      .reset       (reset),
      .pack_valid  (pack_valid),
      .pack_entry  (pack_entry),
      .pack_ready  (pack_ready),
      .head_valid  (head_valid),
      .head_entry  (head_entry),
      .pop         (pop),
      .entries     (entries),
      .entry_valid (entry_valid),
      .wr_ptr      (wr_ptr),
      .empty       (empty),
      .full        (full)
   );

   stbuf_drain drain_i (
      .clk        (clk),
      .reset      (reset),
      .head_valid (head_valid),
      .head_entry (head_entry),
      .pop        (pop),
      .mem_valid  (mem_valid),
      .mem_req    (mem_req),
      .mem_ready  (mem_ready)
   );

   // drain request counts as pending until the memory takes it
   stbuf_forward forward_i (
      .clk         (clk),
      .reset       (reset),
      .ld_valid    (ld_valid),
      .ld_addr     (ld_addr),
      .entries     (entries),
      .entry_valid (entry_valid),
      .wr_ptr      (wr_ptr),
      .drain_valid (mem_valid),
      .drain_entry (mem_req),
      .pack_valid  (pack_valid),
      .pack_entry  (pack_entry),
      .fwd_valid   (fwd_valid),
      .fwd         (fwd)
   );

endmodule

`default_nettype wire

/* testbench/stbuf_test_table.svh */
// stimulus rows with expected forwarding results, included inside the store buffer testbench
`ifndef STBUF_TEST_TABLE_SVH
`define STBUF_TEST_TABLE_SVH

// columns: name, operation, address, size, data, expected fwd byteen, expected fwd data
function automatic void build_table();
   // ------------------------------------------------------------
   // every size and aligned offset, random data, random stalls
   // ------------------------------------------------------------
   add_row("byte_off0",   OP_STORE_RND, 16'h0100, SIZE_BYTE, 32'h0, 4'h0, 32'h0);
   add_row("byte_off1",   OP_STORE_RND, 16'h0101, SIZE_BYTE, 32'h0, 4'h0, 32'h0);
   add_row("byte_off2",   OP_STORE_RND, 16'h0102, SIZE_BYTE, 32'h0, 4'h0, 32'h0);
   add_row("byte_off3",   OP_STORE_RND, 16'h0103, SIZE_BYTE, 32'h0, 4'h0, 32'h0);
   add_row("half_off0",   OP_STORE_RND, 16'h0104, SIZE_HALF, 32'h0, 4'h0, 32'h0);
   add_row("half_off2",   OP_STORE_RND, 16'h0106, SIZE_HALF, 32'h0, 4'h0, 32'h0);
   add_row("word_off0",   OP_STORE_RND, 16'h0108, SIZE_WORD, 32'h0, 4'h0, 32'h0);
   add_row("word_next",   OP_STORE_RND, 16'h010c, SIZE_WORD, 32'h0, 4'h0, 32'h0);
   add_row("drain_sizes", OP_DRAIN,     16'h0000, SIZE_WORD, 32'h0, 4'h0, 32'h0);

   // ------------------------------------------------------------
   // memory held off, fill to DEPTH+2, overlapping stores
   // ------------------------------------------------------------
   add_row("hold_mem",    OP_HOLD,  16'h0000, SIZE_WORD, 32'h0,        4'h0, 32'h0);
   add_row("fill_word",   OP_STORE, 16'h0200, SIZE_WORD, 32'h11223344, 4'h0, 32'h0);
   add_row("fill_byte1",  OP_STORE, 16'h0201, SIZE_BYTE, 32'h000000aa, 4'h0, 32'h0);
   add_row("fill_half2",  OP_STORE, 16'h0202, SIZE_HALF, 32'h0000bbcc, 4'h0, 32'h0);
   add_row("other_half",  OP_STORE, 16'h0302, SIZE_HALF, 32'h0000dead, 4'h0, 32'h0);
   add_row("other_byte3", OP_STORE, 16'h0303, SIZE_BYTE, 32'h0000005a, 4'h0, 32'h0);
   add_row("fill_byte0",  OP_STORE, 16'h0200, SIZE_BYTE, 32'h00000077, 4'h0, 32'h0);
   add_row("full_check",  OP_FULL,  16'h0000, SIZE_WORD, 32'h0,        4'h0, 32'h0);
   add_row("fwd_youngest", OP_LOAD, 16'h0200, SIZE_WORD, 32'h0, 4'hf, 32'hbbccaa77);
   add_row("fwd_offset",   OP_LOAD, 16'h0203, SIZE_WORD, 32'h0, 4'hf, 32'hbbccaa77);
   add_row("fwd_partial",  OP_LOAD, 16'h0300, SIZE_WORD, 32'h0, 4'hc, 32'h5aad0000);
   add_row("fwd_no_match", OP_LOAD, 16'h0400, SIZE_WORD, 32'h0, 4'h0, 32'h0);
   add_row("drain_all",    OP_DRAIN, 16'h0000, SIZE_WORD, 32'h0, 4'h0, 32'h0);
   add_row("fwd_drained",  OP_LOAD, 16'h0200, SIZE_WORD, 32'h0, 4'h0, 32'h0);
   add_row("fwd_drained2", OP_LOAD, 16'h0302, SIZE_WORD, 32'h0, 4'h0, 32'h0);

   // one more random round
   add_row("rnd_half_hi", OP_STORE_RND, 16'h0512, SIZE_HALF, 32'h0, 4'h0, 32'h0);
   add_row("rnd_byte1",   OP_STORE_RND, 16'h0521, SIZE_BYTE, 32'h0, 4'h0, 32'h0);
   add_row("rnd_word",    OP_STORE_RND, 16'h0534, SIZE_WORD, 32'h0, 4'h0, 32'h0);
   add_row("rnd_byte3",   OP_STORE_RND, 16'h0543, SIZE_BYTE, 32'h0, 4'h0, 32'h0);
   add_row("drain_final", OP_DRAIN,     16'h0000, SIZE_WORD, 32'h0, 4'h0, 32'h0);
endfunction

`endif

/* testbench/tb_lsu_stbuf.sv */
// self-checking testbench that runs the row table against a data memory model of the store buffer
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_stbuf
   import stbuf_pkg::*;
();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 10;
   localparam int WAIT_LIMIT   = 40;   // cycles allowed for one store or one drain

   typedef enum logic [2:0] {
      OP_STORE, OP_STORE_RND, OP_LOAD, OP_DRAIN, OP_HOLD, OP_FULL
   } test_op_e;

   typedef struct packed {
      test_op_e              op;
      logic [ADDR_WIDTH-1:0] addr;
      access_size_e          size;
      logic [DATA_WIDTH-1:0] data;
      logic [BYTE_WIDTH-1:0] exp_byteen;
      logic [DATA_WIDTH-1:0] exp_data;
   } test_row_t;

   logic                  clk;
   logic                  reset;
   logic                  store_valid;
   store_req_t            store;
   logic                  store_ready;
   logic                  mem_valid;
   stbuf_entry_t          mem_req;
   logic                  mem_ready;
   logic                  ld_valid;
   logic [ADDR_WIDTH-1:0] ld_addr;
   logic                  fwd_valid;
   fwd_result_t           fwd;
   logic                  empty;
   logic                  full;

   test_row_t    rows[$];
   string        row_names[$];
   stbuf_entry_t exp_q[$];       // accepted stores still waiting for their write
   string        exp_names[$];
   logic [7:0]   mem_bytes[logic [ADDR_WIDTH-1:0]];
   logic [7:0]   exp_bytes[logic [ADDR_WIDTH-1:0]];   // final byte values in store order
   logic         hold_mem;
   logic         table_built;
   int           errors;
   int           write_errors;
   int           mem_writes;

   lsu_stbuf lsu_stbuf_i (.*);

   // ------------------------------------------------------------
   // helpers
   // ------------------------------------------------------------
   function automatic void add_row(input string name, input test_op_e op,
                                   input logic [ADDR_WIDTH-1:0] addr, input access_size_e size,
                                   input logic [DATA_WIDTH-1:0] data,
                                   input logic [BYTE_WIDTH-1:0] exp_byteen,
                                   input logic [DATA_WIDTH-1:0] exp_data);
      test_row_t r;
      r = '{op, addr, size, data, exp_byteen, exp_data};
      rows.push_back(r);
      row_names.push_back(name);
   endfunction

   `include "stbuf_test_table.svh"

   // only the bytes of the access placed at their lanes
   function automatic stbuf_entry_t pack_expected(input store_req_t s);
      stbuf_entry_t e;
      int           off;
      int           nbytes;
      e   = '0;
      off = int'(s.addr[OFFSET_WIDTH-1:0]);
      case (s.size)
         SIZE_BYTE: nbytes = 1;
         SIZE_HALF: nbytes = 2;
         default:   nbytes = 4;
      endcase
      e.word_addr = s.addr[ADDR_WIDTH-1:OFFSET_WIDTH];
      for (int b = 0; b < nbytes; b++) begin
         e.byteen[off+b]        = 1'b1;
         e.data[8*(off+b) +: 8] = s.data[8*b +: 8];
      end
      return e;
   endfunction

   function automatic logic [DATA_WIDTH-1:0] lane_mask(input logic [BYTE_WIDTH-1:0] be);
      logic [DATA_WIDTH-1:0] m;
      for (int b = 0; b < BYTE_WIDTH; b++) begin
         m[8*b +: 8] = {8{be[b]}};
      end
      return m;
   endfunction

   function automatic void report_mismatch(input string name, input string what,
                                           input logic [63:0] expv, input logic [63:0] actv);
      $display("Error: %s: %s expected %0h, got %0h", name, what, expv, actv);
      errors++;
   endfunction

   task automatic push_store(input string name, input store_req_t s);
      stbuf_entry_t e;
      int           waited;
      waited      = 0;
      e           = pack_expected(s);
      store_valid = 1'b1;
      store       = s;
      while (store_ready !== 1'b1 && waited < WAIT_LIMIT) begin
         @(posedge clk);
         #1;
         waited++;
      end
      if (store_ready !== 1'b1) begin
         $display("Store %s was never accepted", name);
         errors++;
      end else begin
         @(posedge clk);   // transfer edge
         #1;
         exp_q.push_back(e);
         exp_names.push_back(name);
         for (int b = 0; b < BYTE_WIDTH; b++) begin
            if (e.byteen[b]) exp_bytes[{e.word_addr, 2'(b)}] = e.data[8*b +: 8];
         end
      end
      store_valid = 1'b0;
   endtask

   task automatic run_row(input string name, input test_row_t r);
      store_req_t s;
      int         waited;
      s.addr = r.addr;
      s.size = r.size;
      s.data = (r.op == OP_STORE_RND) ? $urandom() : r.data;
      waited = 0;
      case (r.op)
         OP_STORE, OP_STORE_RND: push_store(name, s);
         OP_HOLD: begin
            hold_mem = 1'b1;
            repeat (2) @(posedge clk);
            #1;
         end
         OP_LOAD: begin
            ld_valid = 1'b1;
            ld_addr  = r.addr;
            @(posedge clk);
            #1;
            ld_valid = 1'b0;
            if (fwd_valid !== 1'b1)
               report_mismatch(name, "fwd_valid", 64'd1, 64'(fwd_valid));
            if (fwd.byteen !== r.exp_byteen)
               report_mismatch(name, "fwd byteen", 64'(r.exp_byteen), 64'(fwd.byteen));
            if (fwd.data !== r.exp_data)
               report_mismatch(name, "fwd data", 64'(r.exp_data), 64'(fwd.data));
         end
         OP_FULL: begin
            repeat (4) begin
               if (store_ready !== 1'b0)
                  report_mismatch(name, "store_ready", 64'd0, 64'(store_ready));
               if (full !== 1'b1)
                  report_mismatch(name, "full", 64'd1, 64'(full));
               if (empty !== 1'b0)
                  report_mismatch(name, "empty", 64'd0, 64'(empty));
               @(posedge clk);
               #1;
            end
         end
         OP_DRAIN: begin
            hold_mem = 1'b0;
            while ((exp_q.size() != 0 || mem_valid) && waited < WAIT_LIMIT) begin
               @(posedge clk);
               #1;
               waited++;
            end
            if (exp_q.size() != 0) begin
               $display("Drain %s left %0d stores unwritten", name, exp_q.size());
               errors++;
            end
            if (empty !== 1'b1)
               report_mismatch(name, "empty", 64'd1, 64'(empty));
            if (full !== 1'b0)
               report_mismatch(name, "full", 64'd0, 64'(full));
            foreach (exp_bytes[a]) begin
               if (!mem_bytes.exists(a)) begin
                  $display("Drain %s found memory byte %0h never written", name, a);
                  errors++;
               end else if (mem_bytes[a] !== exp_bytes[a]) begin
                  report_mismatch(name, $sformatf("memory byte %0h", a),
                                  64'(exp_bytes[a]), 64'(mem_bytes[a]));
               end
            end
         end
      endcase
   endtask

   // ------------------------------------------------------------
   // clock, memory side and watchdog
   // ------------------------------------------------------------
   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   initial begin : mem_ready_driver
      logic ready_next;
      mem_ready = 1'b0;
      forever begin
         @(posedge clk);
         ready_next = ~hold_mem & (($urandom() & 32'h3) != 32'h0);   // ready 3 cycles in 4
         #1;
         mem_ready = ready_next;
      end
   end

   // byte memory that checks every write in order against the accepted stores
   always @(posedge clk) begin : memory_model
      stbuf_entry_t exp_e;
      stbuf_entry_t act;
      string        name;
      if (!reset && mem_valid && mem_ready) begin
         act      = mem_req;
         act.data = mem_req.data & lane_mask(mem_req.byteen);
         for (int b = 0; b < BYTE_WIDTH; b++) begin
            if (mem_req.byteen[b]) mem_bytes[{mem_req.word_addr, 2'(b)}] = mem_req.data[8*b +: 8];
         end
         mem_writes++;
         if (exp_q.size() == 0) begin
            $display("Memory write %0h arrived with no store pending", mem_req);
            write_errors++;
         end else begin
            exp_e = exp_q.pop_front();
            name  = exp_names.pop_front();
            if (act !== exp_e) begin
               $display("Error: %s: mem_req expected %0h, got %0h", name, exp_e, act);
               write_errors++;
            end
         end
      end
   end

   initial begin : watchdog
      wait (table_built === 1'b1);
      repeat (rows.size() * 50 + RESET_CYCLES) @(posedge clk);
      $display("Timeout: the test table did not finish in time");
      $display("Simulation failed");
      $finish;
   end

   // ------------------------------------------------------------
   // main sequence
   // ------------------------------------------------------------
   initial begin : main
      store_valid = 1'b0;
      store       = '0;
      ld_valid    = 1'b0;
      ld_addr     = '0;
      hold_mem    = 1'b0;
      reset       = 1'b1;
      errors      = 0;
      void'($urandom(94));
      build_table();
      table_built = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #1;
      reset = 1'b0;
      if (store_ready !== 1'b1) report_mismatch("reset", "store_ready", 64'd1, 64'(store_ready));
      if (mem_valid !== 1'b0) report_mismatch("reset", "mem_valid", 64'd0, 64'(mem_valid));
      if (fwd_valid !== 1'b0) report_mismatch("reset", "fwd_valid", 64'd0, 64'(fwd_valid));
      if (empty !== 1'b1) report_mismatch("reset", "empty", 64'd1, 64'(empty));
      if (full !== 1'b0) report_mismatch("reset", "full", 64'd0, 64'(full));
      foreach (rows[i]) run_row(row_names[i], rows[i]);
      $display("Rows %0d, memory writes %0d, errors %0d", rows.size(), mem_writes,
               errors + write_errors);
      if (errors + write_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+testbench
common/stbuf_pkg.sv
stbuf/store_packer.sv
stbuf/stbuf_queue.sv
stbuf/stbuf_forward.sv
stbuf/stbuf_drain.sv
src/lsu_stbuf.sv
testbench/tb_lsu_stbuf.sv

/* run_sim.sh */
#!/bin/sh
# builds the store buffer testbench with Verilator, runs it and looks for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
   --top-module tb_lsu_stbuf \
   -f verilog.f \
   -o sim_lsu_stbuf

output=$(./obj_dir/sim_lsu_stbuf)
printf '%s\n' "$output"

if printf '%s\n' "$output" | grep -qx "Simulation completed successfully"; then
   exit 0
fi

echo "run_sim: pass message not found"
exit 1
